// ==== compile.f ====
+incdir+verilog
+incdir+dv
verilog/cpu4_pkg.sv
verilog/fetch_decode.sv
verilog/register_file.sv
verilog/execute_unit.sv
verilog/cpu4_top.sv
dv/cpu4_tb.sv

// ==== dv/cpu4_asm.svh ====
`ifndef CPU4_ASM_SVH
`define CPU4_ASM_SVH

// ----------------------------------------------------------------------
// instruction word builders for the test programs
// ----------------------------------------------------------------------

function automatic logic [11:0] nop_insn();
  return {OPC_NOP, 8'h00};
endfunction

function automatic logic [11:0] halt_insn();
  return {OPC_HALT, 8'h00};
endfunction

// target replaces the low eight pc bits.
function automatic logic [11:0] jump_insn(opc_t cond, logic [7:0] target);
  return {cond, target};
endfunction

function automatic logic [11:0] ldx_insn(logic [7:0] value);
  return {OPC_LDX, value};
endfunction

function automatic logic [11:0] ldy_insn(logic [7:0] value);
  return {OPC_LDY, value};
endfunction

function automatic logic [11:0] ldi_insn(operand_t r, logic [3:0] value);
  return {OPC_LDI, 2'b00, r, value};
endfunction

// only add, sub, and, or fit the two op bits.
function automatic logic [11:0] alui_insn(alu_op_t op, operand_t r, logic [3:0] value);
  logic [1:0] code;
  case (op)
    ALU_ADD: code = 2'd0;
    ALU_SUB: code = 2'd1;
    ALU_AND: code = 2'd2;
    default: code = 2'd3;
  endcase
  return {OPC_ALUI, code, r, value};
endfunction

function automatic logic [11:0] alur_insn(alu_op_t op, operand_t r, operand_t q);
  return {OPC_ALUR, op, 1'b0, r, q};
endfunction

function automatic logic [11:0] incp_insn(logic use_y);
  return {OPC_INCP, 7'd0, use_y};
endfunction

`endif

// ==== dv/cpu4_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu4_cfg.svh"

module cpu4_tb import cpu4_pkg::*; ();

  // worst case executed instructions per test, summed.
  localparam int MAX_INSNS   = 8 + 43 + 50 + 46 + 11;
  localparam int CYCLE_LIMIT = 4 * MAX_INSNS + 100;

  logic                     clk;
  logic                     reset_n;
  logic [`CPU4_ROM_AW-1:0]  rom_addr;
  logic [`CPU4_INSN_W-1:0]  rom_data;
  logic [`CPU4_RAM_AW-1:0]  memory_addr;
  logic                     memory_write_en;
  logic [`CPU4_DATA_W-1:0]  memory_write_data;
  logic [`CPU4_DATA_W-1:0]  memory_read_data;
  logic                     halt;

  logic [`CPU4_INSN_W-1:0]  rom_mem [0:(1 << `CPU4_ROM_AW)-1];
  logic [`CPU4_DATA_W-1:0]  ram_mem [0:(1 << `CPU4_RAM_AW)-1];
  logic [`CPU4_INSN_W-1:0]  rom_next;
  logic [`CPU4_DATA_W-1:0]  ram_next;
  logic                     wr_pending;
  logic [`CPU4_RAM_AW-1:0]  wr_addr;
  logic [`CPU4_DATA_W-1:0]  wr_data;

  logic [`CPU4_INSN_W-1:0]  prog [$];
  logic [`CPU4_ROM_AW-1:0]  exp_fetch [$];
  logic [`CPU4_ROM_AW-1:0]  fetch_trace [$];
  logic [`CPU4_RAM_AW-1:0]  exp_waddr [$];
  logic [`CPU4_DATA_W-1:0]  exp_wdata [$];
  logic [`CPU4_RAM_AW-1:0]  log_waddr [$];
  logic [`CPU4_DATA_W-1:0]  log_wdata [$];

  logic [31:0]              lcg_state;
  int                       errors;
  int                       tests_run;
  int                       cycle_count;

  `include "cpu4_asm.svh"

  cpu4_top DUT (
    .clk               (clk),
    .reset_n           (reset_n),
    .rom_addr          (rom_addr),
    .rom_data          (rom_data),
    .memory_addr       (memory_addr),
    .memory_write_en   (memory_write_en),
    .memory_write_data (memory_write_data),
    .memory_read_data  (memory_read_data),
    .halt              (halt)
  );

  always #20 clk = ~clk;

  // ----------------------------------------------------------------------
  // rom and ram models
  // ----------------------------------------------------------------------

  // address sampled mid cycle and data returned just after the next edge.
  always @(negedge clk) begin
    rom_next   = rom_mem[rom_addr];
    wr_pending = (memory_write_en === 1'b1);
    wr_addr    = memory_addr;
    wr_data    = memory_write_data;
    if (!wr_pending) begin
      ram_next = ram_mem[memory_addr];
    end
  end

  always @(posedge clk) begin
    #1;
    rom_data = rom_next;
    if (wr_pending) begin
      ram_mem[wr_addr] = wr_data;
      log_waddr.push_back(wr_addr);
      log_wdata.push_back(wr_data);
      wr_pending = 1'b0;
    end else begin
      memory_read_data = ram_next;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("timeout: halt not reached within %0d cycles", CYCLE_LIMIT);
      $display("tests run: %0d, errors: %0d", tests_run, errors);
      $display("Simulation failed");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // reference model and helpers
  // ----------------------------------------------------------------------

  function automatic logic [3:0] next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[19:16];
  endfunction

  // {carry, result}. add carries past 15 and sub carries on borrow.
  function automatic logic [4:0] alu_model(alu_op_t op, logic [3:0] d, logic [3:0] s,
                                           logic c_in);
    logic [3:0] res;
    logic       c_out;
    c_out = c_in;
    case (op)
      ALU_ADD: begin
        res   = d + s;
        c_out = (int'(d) + int'(s)) > 15;
      end
      ALU_SUB: begin
        res   = d - s;
        c_out = (d < s);
      end
      ALU_AND: res = d & s;
      ALU_OR:  res = d | s;
      ALU_XOR: res = d ^ s;
      default: res = s;
    endcase
    return {c_out, res};
  endfunction

  task automatic start_test(string name);
    $display("test: %s", name);
    tests_run++;
    prog.delete();
    exp_fetch.delete();
    fetch_trace.delete();
    exp_waddr.delete();
    exp_wdata.delete();
    log_waddr.delete();
    log_wdata.delete();
    for (int i = 0; i < (1 << `CPU4_RAM_AW); i++) begin
      ram_mem[i] = i[3:0] ^ i[7:4] ^ i[11:8];
    end
  endtask

  task automatic expect_write(logic [11:0] addr, logic [3:0] data);
    exp_waddr.push_back(addr);
    exp_wdata.push_back(data);
  endtask

  task automatic straight_line_fetches(int count);
    for (int i = 0; i < count; i++) begin
      exp_fetch.push_back(13'(i));
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset_n = 1'b1;
    @(posedge clk);
    @(negedge clk);
    if (halt !== 1'b0) begin
      errors++;
      $display("FAIL %0t halt: expected 0, got %b", $time, halt);
    end
    if (memory_write_en !== 1'b0) begin
      errors++;
      $display("FAIL %0t memory_write_en: expected 0, got %b", $time, memory_write_en);
    end
    @(posedge clk);
    #1;
    reset_n = 1'b0;
  endtask

  // loads prog, runs to halt and checks timing, fetch order and ram writes.
  task automatic run_program();
    int cycles;
    for (int i = 0; i < prog.size(); i++) begin
      rom_mem[i] = prog[i];
    end
    apply_reset();
    cycles = 0;
    @(negedge clk);
    while (halt !== 1'b1) begin
      cycles++;
      if (cycles == 1 && memory_write_en !== 1'b0) begin
        errors++;
        $display("FAIL %0t memory_write_en: expected 0, got %b", $time, memory_write_en);
      end
      if (cycles % 4 == 1) begin
        fetch_trace.push_back(rom_addr);
      end
      @(negedge clk);
    end
    if (cycles != 4 * exp_fetch.size()) begin
      errors++;
      $display("FAIL %0t cycles: expected %0d, got %0d", $time, 4 * exp_fetch.size(), cycles);
    end
    if (fetch_trace.size() != exp_fetch.size()) begin
      errors++;
      $display("wrong number of instructions fetched: expected %0d, saw %0d",
               exp_fetch.size(), fetch_trace.size());
    end
    for (int i = 0; i < fetch_trace.size() && i < exp_fetch.size(); i++) begin
      if (fetch_trace[i] !== exp_fetch[i]) begin
        errors++;
        $display("FAIL %0t rom_addr: expected %0h, got %0h", $time, exp_fetch[i],
                 fetch_trace[i]);
      end
    end
    if (exp_fetch.size() > 0 && rom_addr !== exp_fetch[$] + 1'b1) begin
      errors++;
      $display("FAIL %0t rom_addr: expected %0h, got %0h", $time, exp_fetch[$] + 1'b1,
               rom_addr);
    end
    if (log_waddr.size() != exp_waddr.size()) begin
      errors++;
      $display("FAIL %0t memory_write_en: expected %0d writes, got %0d", $time,
               exp_waddr.size(), log_waddr.size());
    end
    for (int i = 0; i < log_waddr.size() && i < exp_waddr.size(); i++) begin
      if (log_waddr[i] !== exp_waddr[i]) begin
        errors++;
        $display("FAIL %0t memory_addr: expected %0h, got %0h", $time, exp_waddr[i],
                 log_waddr[i]);
      end
      if (log_wdata[i] !== exp_wdata[i]) begin
        errors++;
        $display("FAIL %0t memory_write_data: expected %0h, got %0h", $time, exp_wdata[i],
                 log_wdata[i]);
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // directed tests
  // ----------------------------------------------------------------------

  task automatic reset_and_loads();
    start_test("reset and loads");
    prog.push_back(ldi_insn(OPD_A, 4'h9));
    prog.push_back(ldx_insn(8'h34));
    prog.push_back(alur_insn(ALU_LD, OPD_MX, OPD_A));
    prog.push_back(ldx_insn(8'h35));
    prog.push_back(ldi_insn(OPD_MX, 4'h6));
    prog.push_back(ldy_insn(8'h36));
    prog.push_back(alur_insn(ALU_LD, OPD_MY, OPD_A));
    prog.push_back(halt_insn());
    expect_write(12'h034, 4'h9);
    expect_write(12'h035, 4'h6);
    expect_write(12'h036, 4'h9);
    straight_line_fetches(prog.size());
    run_program();
  endtask

  task automatic alu_operations();
    alu_op_t    ops[5] = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR};
    logic [3:0] v1;
    logic [3:0] v2;
    logic [4:0] r;
    logic [11:0] addr;
    start_test("alu operations");
    addr = 12'h080;
    prog.push_back(ldx_insn(8'h80));
    for (int i = 0; i < 4; i++) begin
      v1 = next_random();
      v2 = next_random();
      r = alu_model(ops[i], v1, v2, 1'b0);
      prog.push_back(ldi_insn(OPD_A, v1));
      prog.push_back(alui_insn(ops[i], OPD_A, v2));
      prog.push_back(alur_insn(ALU_LD, OPD_MX, OPD_A));
      prog.push_back(incp_insn(1'b0));
      expect_write(addr, r[3:0]);
      addr++;
    end
    // register forms.
    for (int i = 0; i < 5; i++) begin
      v1 = next_random();
      v2 = next_random();
      r = alu_model(ops[i], v1, v2, 1'b0);
      prog.push_back(ldi_insn(OPD_A, v1));
      prog.push_back(ldi_insn(OPD_B, v2));
      prog.push_back(alur_insn(ops[i], OPD_A, OPD_B));
      prog.push_back(alur_insn(ALU_LD, OPD_MX, OPD_A));
      prog.push_back(incp_insn(1'b0));
      expect_write(addr, r[3:0]);
      addr++;
    end
    prog.push_back(halt_insn());
    straight_line_fetches(prog.size());
    run_program();
  endtask

  task automatic flags_and_branches();
    opc_t       jcc[8] = '{OPC_JPC, OPC_JPC, OPC_JPNC, OPC_JPNC,
                           OPC_JPZ, OPC_JPZ, OPC_JPNZ, OPC_JPNZ};
    alu_op_t    op[8]  = '{ALU_ADD, ALU_ADD, ALU_SUB, ALU_SUB,
                           ALU_SUB, ALU_ADD, ALU_ADD, ALU_SUB};
    logic [3:0] v1[8]  = '{4'h9, 4'h3, 4'h2, 4'h7, 4'h6, 4'h1, 4'h8, 4'h3};
    logic [3:0] v2[8]  = '{4'h8, 4'h4, 4'h5, 4'h2, 4'h6, 4'h2, 4'h8, 4'h1};
    logic [4:0] r;
    logic       taken;
    logic [7:0] k;
    start_test("flags and branches");
    prog.push_back(ldx_insn(8'ha0));
    exp_fetch.push_back(13'd0);
    // seven words per case with marker i on fall through and i+8 when taken.
    for (int i = 0; i < 8; i++) begin
      k = 8'(1 + 7 * i);
      r = alu_model(op[i], v1[i], v2[i], 1'b0);
      case (jcc[i])
        OPC_JPC:  taken = r[4];
        OPC_JPNC: taken = !r[4];
        OPC_JPZ:  taken = (r[3:0] == 4'h0);
        default:  taken = (r[3:0] != 4'h0);
      endcase
      prog.push_back(ldi_insn(OPD_A, v1[i]));
      prog.push_back(alui_insn(op[i], OPD_A, v2[i]));
      prog.push_back(jump_insn(jcc[i], k + 8'd5));
      prog.push_back(ldi_insn(OPD_MX, 4'(i)));
      prog.push_back(jump_insn(OPC_JP, k + 8'd6));
      prog.push_back(ldi_insn(OPD_MX, 4'(i + 8)));
      prog.push_back(incp_insn(1'b0));
      exp_fetch.push_back(13'(k));
      exp_fetch.push_back(13'(k + 8'd1));
      exp_fetch.push_back(13'(k + 8'd2));
      if (taken) begin
        exp_fetch.push_back(13'(k + 8'd5));
      end else begin
        exp_fetch.push_back(13'(k + 8'd3));
        exp_fetch.push_back(13'(k + 8'd4));
      end
      exp_fetch.push_back(13'(k + 8'd6));
      expect_write(12'(12'h0a0 + i), taken ? 4'(i + 8) : 4'(i));
    end
    prog.push_back(halt_insn());
    exp_fetch.push_back(13'(prog.size() - 1));
    run_program();
  endtask

  task automatic memory_operands_and_pointers();
    logic [3:0] vals[6];
    logic [3:0] acc;
    logic [3:0] carries;
    logic [4:0] r;
    start_test("memory operands and pointers");
    acc = 4'h0;
    carries = 4'h0;
    for (int i = 0; i < 6; i++) begin
      vals[i] = next_random();
      ram_mem[12'h0c0 + i] = vals[i];
    end
    prog.push_back(ldy_insn(8'hc0));
    prog.push_back(ldx_insn(8'hd0));
    prog.push_back(ldi_insn(OPD_MX, 4'h6));
    prog.push_back(ldi_insn(OPD_A, 4'h0));
    prog.push_back(ldi_insn(OPD_B, 4'h0));
    // loop body starts at 5 and keeps its counter in ram at x.
    prog.push_back(alur_insn(ALU_ADD, OPD_A, OPD_MY));
    prog.push_back(jump_insn(OPC_JPNC, 8'd8));
    prog.push_back(alui_insn(ALU_ADD, OPD_B, 4'h1));
    prog.push_back(incp_insn(1'b1));
    prog.push_back(alui_insn(ALU_SUB, OPD_MX, 4'h1));
    prog.push_back(jump_insn(OPC_JPNZ, 8'd5));
    prog.push_back(ldx_insn(8'hd1));
    prog.push_back(alur_insn(ALU_LD, OPD_MX, OPD_A));
    prog.push_back(incp_insn(1'b0));
    prog.push_back(alur_insn(ALU_LD, OPD_MX, OPD_B));
    prog.push_back(halt_insn());
    straight_line_fetches(5);
    expect_write(12'h0d0, 4'h6);
    for (int i = 0; i < 6; i++) begin
      r = alu_model(ALU_ADD, acc, vals[i], 1'b0);
      acc = r[3:0];
      exp_fetch.push_back(13'd5);
      exp_fetch.push_back(13'd6);
      if (r[4]) begin
        carries++;
        exp_fetch.push_back(13'd7);
      end
      exp_fetch.push_back(13'd8);
      exp_fetch.push_back(13'd9);
      exp_fetch.push_back(13'd10);
      expect_write(12'h0d0, 4'(5 - i));
    end
    for (int i = 11; i < 16; i++) begin
      exp_fetch.push_back(13'(i));
    end
    expect_write(12'h0d1, acc);
    expect_write(12'h0d2, carries);
    run_program();
  endtask

  task automatic register_only_timing();
    start_test("timing, register operations only");
    prog.push_back(ldi_insn(OPD_A, 4'h5));
    prog.push_back(ldi_insn(OPD_B, 4'ha));
    prog.push_back(alur_insn(ALU_ADD, OPD_A, OPD_B));
    prog.push_back(alui_insn(ALU_SUB, OPD_B, 4'h3));
    prog.push_back(ldx_insn(8'h12));
    prog.push_back(incp_insn(1'b1));
    prog.push_back(nop_insn());
    prog.push_back(12'hd5a);
    prog.push_back(jump_insn(OPC_JP, 8'd10));
    prog.push_back(ldi_insn(OPD_MX, 4'hf));
    prog.push_back(alur_insn(ALU_XOR, OPD_A, OPD_B));
    prog.push_back(halt_insn());
    straight_line_fetches(9);
    exp_fetch.push_back(13'd10);
    exp_fetch.push_back(13'd11);
    run_program();
  endtask

  initial begin
    clk = 1'b0;
    reset_n = 1'b1;
    rom_data = '0;
    memory_read_data = '0;
    wr_pending = 1'b0;
    lcg_state = 32'd10;
    errors = 0;
    tests_run = 0;
    cycle_count = 0;
    reset_and_loads();
    alu_operations();
    flags_and_branches();
    memory_operands_and_pointers();
    register_only_timing();
    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cpu4_cfg.svh ====
`ifndef CPU4_CFG_SVH
`define CPU4_CFG_SVH

// ----------------------------------------------------------------------
// core widths
// ----------------------------------------------------------------------

// rom address width for 8k instruction words.
`define CPU4_ROM_AW 13

// instruction word.
`define CPU4_INSN_W 12

// ram address and index register width.
`define CPU4_RAM_AW 12

// data path nibble.
`define CPU4_DATA_W 4

`endif

// ==== verilog/cpu4_pkg.sv ====
`default_nettype none

package cpu4_pkg;

  // ----------------------------------------------------------------------
  // instruction groups from ir[11:8]
  // ----------------------------------------------------------------------

  // unused codes decode as a nop.
  typedef enum logic [3:0] {
    OPC_NOP  = 4'h0,
    OPC_HALT = 4'h1,
    OPC_JP   = 4'h2,
    OPC_JPC  = 4'h3,
    OPC_JPNC = 4'h4,
    OPC_JPZ  = 4'h5,
    OPC_JPNZ = 4'h6,
    OPC_LDX  = 4'h7,
    OPC_LDY  = 4'h8,
    OPC_LDI  = 4'h9,
    OPC_ALUI = 4'ha,
    OPC_ALUR = 4'hb,
    OPC_INCP = 4'hc
  } opc_t;

  // ----------------------------------------------------------------------
  // datapath controls
  // ----------------------------------------------------------------------

  // alur carries the full 3-bit code in ir[7:5].
  typedef enum logic [2:0] {
    ALU_LD  = 3'd0,
    ALU_ADD = 3'd1,
    ALU_SUB = 3'd2,
    ALU_AND = 3'd3,
    ALU_OR  = 3'd4,
    ALU_XOR = 3'd5
  } alu_op_t;

  // mx and my address ram through the index registers.
  typedef enum logic [1:0] {
    OPD_A  = 2'd0,
    OPD_B  = 2'd1,
    OPD_MX = 2'd2,
    OPD_MY = 2'd3
  } operand_t;

  typedef enum logic [2:0] {
    PTR_NONE  = 3'd0,
    PTR_LD_X  = 3'd1,
    PTR_LD_Y  = 3'd2,
    PTR_INC_X = 3'd3,
    PTR_INC_Y = 3'd4
  } ptr_op_t;

endpackage

`default_nettype wire

// ==== verilog/cpu4_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu4_cfg.svh"

module cpu4_top import cpu4_pkg::*; (
  input  wire logic                    clk,
  input  wire logic                    reset_n,
  output logic [`CPU4_ROM_AW-1:0]      rom_addr,
  input  wire logic [`CPU4_INSN_W-1:0] rom_data,
  output logic [`CPU4_RAM_AW-1:0]      memory_addr,
  output logic                         memory_write_en,
  output logic [`CPU4_DATA_W-1:0]      memory_write_data,
  input  wire logic [`CPU4_DATA_W-1:0] memory_read_data,
  output logic                         halt
);

  // decoded controls.
  alu_op_t                 alu_op;
  operand_t                dest_sel;
  operand_t                src_sel;
  logic                    src_is_imm;
  logic [`CPU4_DATA_W-1:0] imm;
  logic                    write_back;
  ptr_op_t                 ptr_op;
  logic [7:0]              ptr_imm;
  logic                    exec;

  // register state.
  logic [`CPU4_DATA_W-1:0] a;
  logic [`CPU4_DATA_W-1:0] b;
  logic [`CPU4_RAM_AW-1:0] x;
  logic [`CPU4_RAM_AW-1:0] y;
  logic                    carry;
  logic                    zero;

  // alu writeback.
  logic [`CPU4_DATA_W-1:0] result;
  logic                    new_carry;
  logic                    new_zero;
  logic                    flag_we;

  fetch_decode u_fetch_decode (
    .clk        (clk),
    .reset_n    (reset_n),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .carry      (carry),
    .zero       (zero),
    .alu_op     (alu_op),
    .dest_sel   (dest_sel),
    .src_sel    (src_sel),
    .src_is_imm (src_is_imm),
    .imm        (imm),
    .write_back (write_back),
    .ptr_op     (ptr_op),
    .ptr_imm    (ptr_imm),
    .exec       (exec),
    .halt       (halt)
  );

  register_file u_register_file (
    .clk        (clk),
    .reset_n    (reset_n),
    .exec       (exec),
    .write_back (write_back),
    .flag_we    (flag_we),
    .dest_sel   (dest_sel),
    .result     (result),
    .new_carry  (new_carry),
    .new_zero   (new_zero),
    .ptr_op     (ptr_op),
    .ptr_imm    (ptr_imm),
    .a          (a),
    .b          (b),
    .x          (x),
    .y          (y),
    .carry      (carry),
    .zero       (zero)
  );

  execute_unit u_execute_unit (
    .alu_op            (alu_op),
    .dest_sel          (dest_sel),
    .src_sel           (src_sel),
    .src_is_imm        (src_is_imm),
    .write_back        (write_back),
    .exec              (exec),
    .imm               (imm),
    .a                 (a),
    .b                 (b),
    .x                 (x),
    .y                 (y),
    .carry             (carry),
    .memory_read_data  (memory_read_data),
    .result            (result),
    .new_carry         (new_carry),
    .new_zero          (new_zero),
    .flag_we           (flag_we),
    .memory_addr       (memory_addr),
    .memory_write_en   (memory_write_en),
    .memory_write_data (memory_write_data)
  );

endmodule

`default_nettype wire

// ==== verilog/execute_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu4_cfg.svh"

module execute_unit import cpu4_pkg::*; (
  input  wire alu_op_t                 alu_op,
  input  wire operand_t                dest_sel,
  input  wire operand_t                src_sel,
  input  wire logic                    src_is_imm,
  input  wire logic                    write_back,
  input  wire logic                    exec,
  input  wire logic [`CPU4_DATA_W-1:0] imm,
  input  wire logic [`CPU4_DATA_W-1:0] a,
  input  wire logic [`CPU4_DATA_W-1:0] b,
  input  wire logic [`CPU4_RAM_AW-1:0] x,
  input  wire logic [`CPU4_RAM_AW-1:0] y,
  input  wire logic                    carry,
  input  wire logic [`CPU4_DATA_W-1:0] memory_read_data,
  output logic [`CPU4_DATA_W-1:0]      result,
  output logic                         new_carry,
  output logic                         new_zero,
  output logic                         flag_we,
  output logic [`CPU4_RAM_AW-1:0]      memory_addr,
  output logic                         memory_write_en,
  output logic [`CPU4_DATA_W-1:0]      memory_write_data
);

  logic [`CPU4_DATA_W-1:0] dst_val;
  logic [`CPU4_DATA_W-1:0] src_val;
  logic [`CPU4_DATA_W:0]   sum;
  logic [`CPU4_DATA_W:0]   diff;
  logic                    dest_in_mem;
  logic                    use_y;

  // ----------------------------------------------------------------------
  // operand selection
  // ----------------------------------------------------------------------

  // the destination doubles as the first alu operand.
  always_comb begin
    case (dest_sel)
      OPD_A:   dst_val = a;
      OPD_B:   dst_val = b;
      default: dst_val = memory_read_data;
    endcase
  end

  always_comb begin
    if (src_is_imm) begin
      src_val = imm;
    end else begin
      case (src_sel)
        OPD_A:   src_val = a;
        OPD_B:   src_val = b;
        default: src_val = memory_read_data;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // alu and flags
  // ----------------------------------------------------------------------

  assign sum  = {1'b0, dst_val} + {1'b0, src_val};
  assign diff = {1'b0, dst_val} - {1'b0, src_val};

  // logic ops keep the old carry.
  always_comb begin
    new_carry = carry;
    flag_we   = write_back;
    case (alu_op)
      ALU_ADD: begin
        result    = sum[`CPU4_DATA_W-1:0];
        new_carry = sum[`CPU4_DATA_W];
      end
      ALU_SUB: begin
        result    = diff[`CPU4_DATA_W-1:0];
        new_carry = diff[`CPU4_DATA_W];
      end
      ALU_AND: result = dst_val & src_val;
      ALU_OR:  result = dst_val | src_val;
      ALU_XOR: result = dst_val ^ src_val;
      default: begin
        result  = src_val;
        flag_we = 1'b0;
      end
    endcase
  end

  assign new_zero = (result == '0);

  // ----------------------------------------------------------------------
  // ram port
  // ----------------------------------------------------------------------

  // address is steady from read through exec since ir does not move.
  assign use_y = (dest_sel == OPD_MY) || (!src_is_imm && src_sel == OPD_MY);
  assign memory_addr = use_y ? y : x;

  assign dest_in_mem       = (dest_sel == OPD_MX) || (dest_sel == OPD_MY);
  assign memory_write_en   = exec && write_back && dest_in_mem;
  assign memory_write_data = result;

endmodule

`default_nettype wire

// ==== verilog/fetch_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu4_cfg.svh"

module fetch_decode import cpu4_pkg::*; (
  input  wire logic                     clk,
  input  wire logic                     reset_n,
  output logic [`CPU4_ROM_AW-1:0]       rom_addr,
  input  wire logic [`CPU4_INSN_W-1:0]  rom_data,
  input  wire logic                     carry,
  input  wire logic                     zero,
  output alu_op_t                       alu_op,
  output operand_t                      dest_sel,
  output operand_t                      src_sel,
  output logic                          src_is_imm,
  output logic [`CPU4_DATA_W-1:0]       imm,
  output logic                          write_back,
  output ptr_op_t                       ptr_op,
  output logic [7:0]                    ptr_imm,
  output logic                          exec,
  output logic                          halt
);

  typedef enum logic [1:0] {
    PH_FETCH  = 2'd0,
    PH_DECODE = 2'd1,
    PH_READ   = 2'd2,
    PH_EXEC   = 2'd3
  } phase_t;

  phase_t                  phase;
  logic [`CPU4_ROM_AW-1:0] pc;
  logic [`CPU4_INSN_W-1:0] ir;
  opc_t                    opc;
  logic                    take_jump;

  // alui only has room for two op bits.
  function automatic alu_op_t alui_op(input logic [1:0] code);
    case (code)
      2'd0:    alui_op = ALU_ADD;
      2'd1:    alui_op = ALU_SUB;
      2'd2:    alui_op = ALU_AND;
      default: alui_op = ALU_OR;
    endcase
  endfunction

  assign rom_addr = pc;
  assign exec     = (phase == PH_EXEC);
  assign opc      = opc_t'(ir[`CPU4_INSN_W-1 -: 4]);
  assign imm      = ir[3:0];
  assign ptr_imm  = ir[7:0];

  // ----------------------------------------------------------------------
  // phase sequencer and instruction register
  // ----------------------------------------------------------------------

  // sits in fetch once halted.
  always_ff @(posedge clk) begin
    if (reset_n) begin
      phase <= PH_FETCH;
    end else if (!halt) begin
      phase <= phase_t'(phase + 2'd1);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_n) begin
      ir <= '0;
    end else if (phase == PH_DECODE) begin
      ir <= rom_data;
    end
  end

  // ----------------------------------------------------------------------
  // program counter and halt
  // ----------------------------------------------------------------------

  always_comb begin
    case (opc)
      OPC_JP:   take_jump = 1'b1;
      OPC_JPC:  take_jump = carry;
      OPC_JPNC: take_jump = !carry;
      OPC_JPZ:  take_jump = zero;
      OPC_JPNZ: take_jump = !zero;
      default:  take_jump = 1'b0;
    endcase
  end

  // jumps stay inside the current 256-word page.
  always_ff @(posedge clk) begin
    if (reset_n) begin
      pc   <= '0;
      halt <= 1'b0;
    end else if (exec) begin
      if (take_jump) begin
        pc <= {pc[`CPU4_ROM_AW-1:8], ir[7:0]};
      end else begin
        pc <= pc + 1'b1;
      end
      if (opc == OPC_HALT) begin
        halt <= 1'b1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // decoder
  // ----------------------------------------------------------------------

  always_comb begin
    alu_op     = ALU_LD;
    dest_sel   = OPD_A;
    src_sel    = OPD_A;
    src_is_imm = 1'b0;
    write_back = 1'b0;
    ptr_op     = PTR_NONE;
    case (opc)
      OPC_LDX: ptr_op = PTR_LD_X;
      OPC_LDY: ptr_op = PTR_LD_Y;
      OPC_INCP: ptr_op = ir[0] ? PTR_INC_Y : PTR_INC_X;
      OPC_LDI, OPC_ALUI: begin
        alu_op     = (opc == OPC_LDI) ? ALU_LD : alui_op(ir[7:6]);
        dest_sel   = operand_t'(ir[5:4]);
        src_is_imm = 1'b1;
        write_back = 1'b1;
      end
      OPC_ALUR: begin
        alu_op     = alu_op_t'(ir[7:5]);
        dest_sel   = operand_t'(ir[3:2]);
        src_sel    = operand_t'(ir[1:0]);
        write_back = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cpu4_cfg.svh"

module register_file import cpu4_pkg::*; (
  input  wire logic                    clk,
  input  wire logic                    reset_n,
  input  wire logic                    exec,
  input  wire logic                    write_back,
  input  wire logic                    flag_we,
  input  wire operand_t                dest_sel,
  input  wire logic [`CPU4_DATA_W-1:0] result,
  input  wire logic                    new_carry,
  input  wire logic                    new_zero,
  input  wire ptr_op_t                 ptr_op,
  input  wire logic [7:0]              ptr_imm,
  output logic [`CPU4_DATA_W-1:0]      a,
  output logic [`CPU4_DATA_W-1:0]      b,
  output logic [`CPU4_RAM_AW-1:0]      x,
  output logic [`CPU4_RAM_AW-1:0]      y,
  output logic                         carry,
  output logic                         zero
);

  logic [`CPU4_RAM_AW-1:0] ptr_load;

  // pointer loads are zero extended.
  assign ptr_load = {{(`CPU4_RAM_AW - 8){1'b0}}, ptr_imm};

  // ----------------------------------------------------------------------
  // accumulators
  // ----------------------------------------------------------------------

  // memory destinations are written by the ram port instead.
  always_ff @(posedge clk) begin
    if (reset_n) begin
      a <= '0;
      b <= '0;
    end else if (exec && write_back) begin
      if (dest_sel == OPD_A) begin
        a <= result;
      end
      if (dest_sel == OPD_B) begin
        b <= result;
      end
    end
  end

  // ----------------------------------------------------------------------
  // flags
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset_n) begin
      carry <= 1'b0;
      zero  <= 1'b0;
    end else if (exec && flag_we) begin
      carry <= new_carry;
      zero  <= new_zero;
    end
  end

  // ----------------------------------------------------------------------
  // index registers
  // ----------------------------------------------------------------------

  // increments wrap at 12 bits.
  always_ff @(posedge clk) begin
    if (reset_n) begin
      x <= '0;
      y <= '0;
    end else if (exec) begin
      case (ptr_op)
        PTR_LD_X:  x <= ptr_load;
        PTR_LD_Y:  y <= ptr_load;
        PTR_INC_X: x <= x + 1'b1;
        PTR_INC_Y: y <= y + 1'b1;
        default:   ;
      endcase
    end
  end

endmodule

`default_nettype wire
